// ==== common/mdio_consts.svh ====
// ---------------------------------------------------------------------------
// Constants for the clause 22 MDIO slave
//   frame field lengths, register count,
//   identifier values and register defaults
// ---------------------------------------------------------------------------

`ifndef MDIO_CONSTS_SVH
`define MDIO_CONSTS_SVH

// Frame fields, in bits
`define MDIO_PREAMBLE_LEN 32   // Minimum run of ones
`define MDIO_ADDR_BITS    5    // PHY and register address
`define MDIO_DATA_BITS    16   // Data field

// Register file
`define MDIO_NUM_REGS     32

// Identifier registers 2 and 3, read only
`define MDIO_PHY_ID1      16'h2a5c
`define MDIO_PHY_ID2      16'h3e91

// Control register default, bit 15 (soft reset) clear
`define MDIO_CTRL_DEFAULT 16'h1140

`endif

// ==== common/mdio_pkg.sv ====
// ---------------------------------------------------------------------------
// Shared types for the clause 22 MDIO management slave
//   mdio_addr_t      PHY or register address
//   mdio_word_t      register value
//   mdio_op_t        frame opcode
//   mdio_reg_req_t   request from frame decoder to register file
// ---------------------------------------------------------------------------

`include "mdio_consts.svh"

package mdio_pkg;

   // Field types
   typedef logic [`MDIO_ADDR_BITS-1:0] mdio_addr_t;   // PHY / register address
   typedef logic [`MDIO_DATA_BITS-1:0] mdio_word_t;   // Register contents

   // Clause 22 opcodes, first bit on the wire is the MSB
   typedef enum logic [1:0]
   {
      op_write = 2'b01,
      op_read  = 2'b10
   } mdio_op_t;

   // What the decoder presents to the register file
   typedef struct packed
   {
      mdio_addr_t addr;    // Register address
      mdio_word_t data;    // Write data, valid with reg_write
   } mdio_reg_req_t;

endpackage

// ==== mdio_slave/mdio_slave.sv ====
// ---------------------------------------------------------------------------
// mdio_slave
//   Clause 22 frame decoder, follows the management frame on mdc
//   Captures PHY address, register address and write data
//   Strobes the register file and shifts read data out MSB first
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

`include "mdio_consts.svh"

module mdio_slave
   import mdio_pkg::*;
(
   input  logic          mdc,
   input  logic          reset,
   input  logic          mdio,          // Sampled line
   input  mdio_addr_t    dev_addr,      // Strapped PHY address
   output mdio_reg_req_t reg_req,
   output logic          reg_read,
   output logic          reg_write,
   input  mdio_word_t    reg_rdata,
   output logic          mdio_data,
   output logic          mdio_enable
);

   // Bit counter compare points
   localparam logic [4:0] pre_last  = 5'(`MDIO_PREAMBLE_LEN - 1);
   localparam logic [4:0] op_last   = 5'd1;
   localparam logic [4:0] addr_last = 5'(`MDIO_ADDR_BITS - 1);
   localparam logic [4:0] data_last = 5'(`MDIO_DATA_BITS - 1);
   localparam logic [4:0] data_end  = 5'(`MDIO_DATA_BITS);   // Read drive done

   typedef enum logic [3:0]
   {
      st_wait,          // Idle, waiting for first preamble one
      st_preamble,      // Counting ones
      st_start,         // Second start bit
      st_opcode,
      st_phy_addr,
      st_reg_addr,
      st_turn,          // First turnaround bit
      st_turn_wr,       // Second turnaround bit, write only
      st_rd_load,       // Read strobe
      st_rd_data,       // Driving turnaround zero and data
      st_wr_data,
      st_wr_strobe      // Write strobe
   } state_t;

   state_t     state;
   logic [4:0] bit_cnt;       // Shared field counter
   mdio_op_t   op_q;          // Decoded opcode
   logic [1:0] op_bits;       // Opcode including current bit
   mdio_addr_t phy_q;         // Captured PHY address
   logic [`MDIO_DATA_BITS:0] out_shift;   // Turnaround zero + read data

   assign op_bits = {op_q[0], mdio};

   // ------------------------------------------------------------------------
   // Frame state machine
   // ------------------------------------------------------------------------
   always_ff @(posedge mdc or posedge reset)
   begin
      if (reset)
      begin
         state       <= st_wait;
         bit_cnt     <= '0;
         op_q        <= op_read;
         mdio_enable <= 1'b0;
      end
      else
      begin
         case (state)
            st_wait:
            begin
               bit_cnt <= '0;
               if (mdio)
                  state <= st_preamble;     // First one of preamble
            end
            st_preamble:
            begin
               if (mdio)
               begin
                  if (bit_cnt != pre_last)
                     bit_cnt <= bit_cnt + 5'd1;   // Saturate once long enough
               end
               else if (bit_cnt == pre_last)
                  state <= st_start;        // Zero is first start bit
               else
                  state <= st_wait;         // Short preamble
            end
            st_start:
            begin
               bit_cnt <= '0;
               state   <= mdio ? st_opcode : st_wait;
            end
            st_opcode:
            begin
               op_q <= mdio_op_t'(op_bits);
               if (bit_cnt != op_last)
                  bit_cnt <= bit_cnt + 5'd1;
               else
               begin
                  bit_cnt <= '0;
                  if (op_bits == op_read || op_bits == op_write)
                     state <= st_phy_addr;
                  else
                     state <= st_wait;      // 00 / 11 not clause 22
               end
            end
            st_phy_addr:
            begin
               if (bit_cnt != addr_last)
                  bit_cnt <= bit_cnt + 5'd1;
               else
               begin
                  bit_cnt <= '0;
                  state   <= st_reg_addr;
               end
            end
            st_reg_addr:
            begin
               if (bit_cnt != addr_last)
                  bit_cnt <= bit_cnt + 5'd1;
               else
               begin
                  bit_cnt <= '0;
                  // Not our address, drop the frame here
                  state   <= (phy_q == dev_addr) ? st_turn : st_wait;
               end
            end
            st_turn:
            begin
               if (!mdio)
                  state <= st_wait;         // Line must be high (released / driven 1)
               else if (op_q == op_read)
                  state <= st_rd_load;
               else
                  state <= st_turn_wr;
            end
            st_turn_wr:
               state <= mdio ? st_wait : st_wr_data;
            st_rd_load:
            begin
               mdio_enable <= 1'b1;         // Drive turnaround zero next
               bit_cnt     <= '0;
               state       <= st_rd_data;
            end
            st_rd_data:
            begin
               if (bit_cnt == data_end)
               begin
                  mdio_enable <= 1'b0;      // 17 cycles driven
                  state       <= st_wait;
               end
               else
                  bit_cnt <= bit_cnt + 5'd1;
            end
            st_wr_data:
            begin
               if (bit_cnt != data_last)
                  bit_cnt <= bit_cnt + 5'd1;
               else
                  state <= st_wr_strobe;    // Last data bit in
            end
            st_wr_strobe:
               state <= st_wait;
            default:
               state <= st_wait;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Field shifters
   // ------------------------------------------------------------------------
   always_ff @(posedge mdc)
   begin
      if (state == st_phy_addr)
         phy_q <= {phy_q[`MDIO_ADDR_BITS-2:0], mdio};
      if (state == st_reg_addr)
         reg_req.addr <= {reg_req.addr[`MDIO_ADDR_BITS-2:0], mdio};
      if (state == st_wr_data)
         reg_req.data <= {reg_req.data[`MDIO_DATA_BITS-2:0], mdio};   // Held through strobe
   end

   // Read data, loaded with a leading zero for the turnaround bit
   always_ff @(posedge mdc)
   begin
      if (state == st_rd_load)
         out_shift <= {1'b0, reg_rdata};
      else if (state == st_rd_data)
         out_shift <= {out_shift[`MDIO_DATA_BITS-1:0], 1'b0};
   end

   assign mdio_data = out_shift[`MDIO_DATA_BITS];   // MSB first

   // Register file strobes, one cycle each
   assign reg_read  = (state == st_rd_load);
   assign reg_write = (state == st_wr_strobe);

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   logic wr_frame;   // Inside a write frame past the opcode

   assign wr_frame = (op_q == op_write) &&
                     (state inside {st_phy_addr, st_reg_addr, st_turn, st_turn_wr,
                                    st_wr_data, st_wr_strobe});

   a_strobe_excl: assert property (@(posedge mdc) disable iff (reset)
      !(reg_read && reg_write));

   a_no_drive_on_write: assert property (@(posedge mdc) disable iff (reset)
      wr_frame |-> !mdio_enable);

endmodule

// ==== source/mdio_reg_file.sv ====
// ---------------------------------------------------------------------------
// mdio_reg_file
//   32 x 16 management registers
//   Registers 2/3 read-only identifiers
//   Register 0 bit 15 self-clearing soft reset
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

`include "mdio_consts.svh"

module mdio_reg_file
   import mdio_pkg::*;
(
   input  logic          mdc,
   input  logic          reset,
   input  mdio_reg_req_t reg_req,
   input  logic          reg_read,
   input  logic          reg_write,
   output mdio_word_t    reg_rdata
);

   localparam mdio_addr_t ctrl_addr = 5'd0;
   localparam mdio_addr_t id1_addr  = 5'd2;
   localparam mdio_addr_t id2_addr  = 5'd3;

   mdio_word_t regs [`MDIO_NUM_REGS];
   mdio_word_t rd_value;
   logic       soft_reset;
   logic       id_hit;        // Write target is an identifier

   assign soft_reset = reg_write && (reg_req.addr == ctrl_addr) && reg_req.data[15];
   assign id_hit     = (reg_req.addr == id1_addr) || (reg_req.addr == id2_addr);

   // ------------------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------------------
   always_ff @(posedge mdc or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < `MDIO_NUM_REGS; i++)
            regs[i] <= (i == 0) ? `MDIO_CTRL_DEFAULT : '0;
      end
      else if (soft_reset)
      begin
         // Defaults everywhere, bit 15 ends up clear
         for (int i = 0; i < `MDIO_NUM_REGS; i++)
            regs[i] <= (i == 0) ? `MDIO_CTRL_DEFAULT : '0;
      end
      else if (reg_write && !id_hit)
         regs[reg_req.addr] <= reg_req.data;
   end

   // Read mux, same cycle as reg_read
   always_comb
   begin
      rd_value = regs[reg_req.addr];
      if (reg_req.addr == id1_addr)
         rd_value = `MDIO_PHY_ID1;
      else if (reg_req.addr == id2_addr)
         rd_value = `MDIO_PHY_ID2;
   end

   assign reg_rdata = reg_read ? rd_value : '0;   // Idle bus at zero

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   a_no_rw_overlap: assert property (@(posedge mdc) disable iff (reset)
      reg_read |-> !reg_write);

endmodule

// ==== source/top_mdio_slave.sv ====
// ---------------------------------------------------------------------------
// top_mdio_slave
//   Clause 22 MDIO slave: frame decoder plus register file
//   Line is split into sampled input and data/enable outputs
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module top_mdio_slave
   import mdio_pkg::*;
(
   input  logic       mdc,
   input  logic       reset,
   input  logic       mdio,          // Line as seen at the pad
   input  mdio_addr_t dev_addr,      // Strapped PHY address
   output logic       mdio_data,     // Pad drive value
   output logic       mdio_enable    // Pad output enable
);

   // Decoder to register file
   mdio_reg_req_t reg_req;
   logic          reg_read;
   logic          reg_write;
   mdio_word_t    reg_rdata;

   mdio_slave mdio_slave_inst
   (
      .mdc         (mdc),
      .reset       (reset),
      .mdio        (mdio),
      .dev_addr    (dev_addr),
      .reg_req     (reg_req),
      .reg_read    (reg_read),
      .reg_write   (reg_write),
      .reg_rdata   (reg_rdata),
      .mdio_data   (mdio_data),
      .mdio_enable (mdio_enable)
   );

   mdio_reg_file mdio_reg_file_inst
   (
      .mdc         (mdc),
      .reset       (reset),
      .reg_req     (reg_req),
      .reg_read    (reg_read),
      .reg_write   (reg_write),
      .reg_rdata   (reg_rdata)
   );

endmodule

// ==== bench/tb_top_mdio_slave.sv ====
// ---------------------------------------------------------------------------
// Directed testbench for the clause 22 MDIO slave
//   MDIO master model with line and pull-up model
//   Compare tasks, LFSR data patterns, cycle timeout
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

`include "mdio_consts.svh"

module tb_top_mdio_slave
   import mdio_pkg::*;
;

   localparam mdio_addr_t phy_addr    = 5'h0b;   // Strapped address of the DUT
   localparam mdio_addr_t other_addr  = 5'h14;
   localparam int         frame_cycles = 70;     // Preamble, fields, idle
   localparam int         num_frames   = 30;
   localparam int         timeout_cycles = 2 * frame_cycles * num_frames;

   logic        mdc;
   logic        reset;
   mdio_addr_t  dev_addr;
   logic        mdio_line;     // Line as seen at the pad
   logic        mdio_data;
   logic        mdio_enable;
   logic        line_out;      // Master drive value
   logic        line_drive;    // Master drives the line
   logic [31:0] lfsr_state;
   int          cycle_cnt;
   mdio_word_t  saved [3];     // Scratch values written in the first test

   // Pad model, DUT wins when enabled, pull-up when nobody drives
   assign mdio_line = mdio_enable ? mdio_data : (line_drive ? line_out : 1'b1);

   top_mdio_slave top_mdio_slave_inst
   (
      .mdc         (mdc),
      .reset       (reset),
      .mdio        (mdio_line),
      .dev_addr    (dev_addr),
      .mdio_data   (mdio_data),
      .mdio_enable (mdio_enable)
   );

   initial
   begin
      mdc = 1'b0;
      forever #4 mdc = ~mdc;   // 8 ns period
   end

   always @(posedge mdc)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles)
      begin
         $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
         $display("TEST FAILED");
         $fatal(1, "stopped on timeout");
      end
   end

   // ------------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------------
   task automatic check_word(input string name, input mdio_word_t expected,
                             input mdio_word_t actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "stopped on first error");
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "stopped on first error");
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual != expected)
      begin
         $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "stopped on first error");
      end
   endtask

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic mdio_word_t next_rand_word();
      mdio_word_t w;
      logic       fb;
      w = '0;
      for (int i = 0; i < `MDIO_DATA_BITS; i++)
      begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         w          = {w[`MDIO_DATA_BITS-2:0], fb};
      end
      return w;
   endfunction

   // ------------------------------------------------------------------------
   // MDIO master model
   // ------------------------------------------------------------------------
   task automatic send_bits(input logic [31:0] value, input int len);
      for (int i = len - 1; i >= 0; i--)
      begin
         @(posedge mdc);
         line_out   <= value[i];   // MSB first
         line_drive <= 1'b1;
      end
   endtask

   task automatic release_line(input int idle);
      @(posedge mdc);
      line_drive <= 1'b0;
      repeat (idle) @(posedge mdc);   // Let the strobe and update settle
   endtask

   // Preamble, start, opcode, PHY and register address
   task automatic send_head(input int pre_len, input logic [1:0] start, input mdio_op_t op,
                            input mdio_addr_t phy, input mdio_addr_t regad);
      for (int i = 0; i < pre_len; i++)
         send_bits(32'h1, 1);
      send_bits(32'(start), 2);
      send_bits(32'(op), 2);
      send_bits(32'(phy), `MDIO_ADDR_BITS);
      send_bits(32'(regad), `MDIO_ADDR_BITS);
   endtask

   task automatic mdio_write_frame(input int pre_len, input logic [1:0] start,
                                   input mdio_addr_t phy, input mdio_addr_t regad,
                                   input mdio_word_t data);
      send_head(pre_len, start, op_write, phy, regad);
      send_bits(32'h2, 2);                          // Turnaround 10
      send_bits(32'(data), `MDIO_DATA_BITS);
      release_line(4);
   endtask

   // Reads one register, checks the 17-cycle drive window
   task automatic mdio_read_frame(input mdio_addr_t phy, input mdio_addr_t regad,
                                  output mdio_word_t data);
      int wait_cnt;
      int hi_cnt;
      wait_cnt = 0;
      hi_cnt   = 0;
      data     = '0;
      send_head(`MDIO_PREAMBLE_LEN, 2'b01, op_read, phy, regad);
      @(posedge mdc);
      line_drive <= 1'b0;           // First turnaround bit from pull-up
      @(negedge mdc);
      while (!mdio_enable)
      begin
         wait_cnt++;
         if (wait_cnt > 4)
         begin
            $display("Read of register %0d: DUT never enabled its output", regad);
            $display("TEST FAILED");
            $fatal(1, "stopped on first error");
         end
         @(negedge mdc);
      end
      while (mdio_enable)
      begin
         if (hi_cnt == 0)
            check_bit("mdio_data turnaround", 1'b0, mdio_data);
         else
            data = {data[`MDIO_DATA_BITS-2:0], mdio_data};
         hi_cnt++;
         if (hi_cnt > 20)
         begin
            $display("Read of register %0d: DUT kept driving the line", regad);
            $display("TEST FAILED");
            $fatal(1, "stopped on first error");
         end
         @(negedge mdc);
      end
      check_count("mdio_enable cycles", `MDIO_DATA_BITS + 1, hi_cnt);
   endtask

   task automatic read_expect(input mdio_addr_t regad, input mdio_word_t expected);
      mdio_word_t got;
      mdio_read_frame(phy_addr, regad, got);
      check_word($sformatf("register %0d", regad), expected, got);
   endtask

   // Read addressed elsewhere, line must stay with the master
   task automatic read_ignored(input mdio_addr_t phy, input mdio_addr_t regad);
      send_head(`MDIO_PREAMBLE_LEN, 2'b01, op_read, phy, regad);
      @(posedge mdc);
      line_drive <= 1'b0;
      repeat (24)
      begin
         @(negedge mdc);
         check_bit("mdio_enable", 1'b0, mdio_enable);
      end
   endtask

   // ------------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------------
   task automatic scratch_readback();
      for (int i = 0; i < 3; i++)
      begin
         saved[i] = next_rand_word();
         mdio_write_frame(`MDIO_PREAMBLE_LEN, 2'b01, phy_addr, 5'(16 + i), saved[i]);
      end
      for (int i = 0; i < 3; i++)
         read_expect(5'(16 + i), saved[i]);
   endtask

   task automatic identifier_regs();
      read_expect(5'd2, `MDIO_PHY_ID1);
      read_expect(5'd3, `MDIO_PHY_ID2);
      mdio_write_frame(`MDIO_PREAMBLE_LEN, 2'b01, phy_addr, 5'd2, next_rand_word());
      mdio_write_frame(`MDIO_PREAMBLE_LEN, 2'b01, phy_addr, 5'd3, next_rand_word());
      read_expect(5'd2, `MDIO_PHY_ID1);   // Writes ignored
      read_expect(5'd3, `MDIO_PHY_ID2);
   endtask

   task automatic addr_mismatch();
      mdio_word_t old_value;
      old_value = next_rand_word();
      mdio_write_frame(`MDIO_PREAMBLE_LEN, 2'b01, phy_addr, 5'd10, old_value);
      mdio_write_frame(`MDIO_PREAMBLE_LEN, 2'b01, other_addr, 5'd10, ~old_value);
      read_expect(5'd10, old_value);
      read_ignored(other_addr, 5'd10);
   endtask

   task automatic soft_reset_clear();
      mdio_write_frame(`MDIO_PREAMBLE_LEN, 2'b01, phy_addr, 5'd0, 16'h0100);
      read_expect(5'd0, 16'h0100);
      mdio_write_frame(`MDIO_PREAMBLE_LEN, 2'b01, phy_addr, 5'd0, 16'h8000);
      read_expect(5'd0, `MDIO_CTRL_DEFAULT);   // Bit 15 already clear
      for (int i = 0; i < 3; i++)
         read_expect(5'(16 + i), 16'h0000);
   endtask

   task automatic malformed_frames();
      mdio_word_t good;
      good = next_rand_word();
      send_bits(32'h0, 2);                     // Break any run of idle ones
      mdio_write_frame(20, 2'b01, phy_addr, 5'd12, 16'hffff);
      read_expect(5'd12, 16'h0000);
      mdio_write_frame(`MDIO_PREAMBLE_LEN, 2'b00, phy_addr, 5'd12, 16'hffff);
      read_expect(5'd12, 16'h0000);            // Bad start code, no write
      mdio_write_frame(`MDIO_PREAMBLE_LEN, 2'b01, phy_addr, 5'd12, good);
      read_expect(5'd12, good);
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      reset      = 1'b1;
      dev_addr   = phy_addr;
      line_out   = 1'b1;
      line_drive = 1'b0;
      lfsr_state = 32'hc494;
      cycle_cnt  = 0;
      repeat (4) @(posedge mdc);
      reset <= 1'b0;
      @(posedge mdc);
      scratch_readback();
      identifier_regs();
      addr_mismatch();
      soft_reset_clear();
      malformed_frames();
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== top_mdio_slave.f ====
+incdir+common
common/mdio_pkg.sv
mdio_slave/mdio_slave.sv
source/mdio_reg_file.sv
source/top_mdio_slave.sv
bench/tb_top_mdio_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MDIO slave testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f top_mdio_slave.f \
   --top-module tb_top_mdio_slave -o sim_tb
out=$(./obj_dir/sim_tb 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "^TEST OK$"; then
   exit 0
else
   exit 1
fi
